// File: bench/id_stage_tb.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage_tb;

    import id_pkg::*;

    // phase lengths in cycles
    localparam int LEN_RESET = 5;
    localparam int LEN_RF    = 32 + 32 * 3;
    localparam int LEN_DEC   = 7 * 3;
    localparam int LEN_FWD   = 12;
    localparam int LEN_STALL = 14;
    localparam int LEN_BR    = 6 * 3 + 4;
    // watchdog limit is twice the phase total
    localparam int MAX_CYCLES = 2 * (LEN_RESET + LEN_RF + LEN_DEC + LEN_FWD + LEN_STALL + LEN_BR);

    logic        clk;
    logic        reset;
    logic        fs_to_ds_valid;
    word_t       fs_inst;
    word_t       fs_pc;
    logic        es_allowin;
    logic        es_res_valid;
    reg_addr_t   es_dest;
    word_t       es_res;
    logic        ms_res_valid;
    reg_addr_t   ms_dest;
    word_t       ms_res;
    logic        ws_we;
    reg_addr_t   ws_waddr;
    word_t       ws_wdata;
    logic        ds_allowin;
    logic        ds_to_es_valid;
    alu_op_e     alu_op;
    logic        src1_is_sa;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        src2_is_8;
    logic        gr_we;
    logic        mem_re;
    logic        mem_we;
    reg_addr_t   dest;
    logic [15:0] imm;
    word_t       rs_value;
    word_t       rt_value;
    word_t       ds_pc;
    logic        br_taken;
    word_t       br_target;

    int          errors;
    int          cycles;
    logic [31:0] rng_state;
    word_t       shadow [`ID_NREGS];   // what the writeback port put in each register
    word_t       cur_pc;
    word_t       pc4;
    word_t       v;
    word_t       fa;
    word_t       fb;
    word_t       fc;
    logic [15:0] im;
    logic [25:0] idx;

    id_stage u_id_stage (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // held instruction under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |-> !ds_allowin)
    else begin
        errors = errors + 1;
        $display("Fail %0t: ds_allowin high while execute stalls", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |=> ($stable(ds_pc) && $stable(dest)
                                             && $stable(alu_op) && $stable(imm)))
    else begin
        errors = errors + 1;
        $display("Fail %0t: held outputs changed under back-pressure", $time);
    end

    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t encode_r(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input logic [4:0] sa,
                                       input funct_e fn);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t encode_i(input opcode_e op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] k);
        return {op, rs, rt, k};
    endfunction

    task automatic expect_word(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp)
        else begin
            errors = errors + 1;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // fetch hands over one instruction and then leaves the delay slot pc on fs_pc
    task automatic send(input word_t inst);
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_inst        <= inst;
        fs_pc          <= cur_pc;
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        fs_pc          <= cur_pc + 4;
        cur_pc = cur_pc + 4;
        @(negedge clk);
    endtask

    task automatic wait_valid();
        while (ds_to_es_valid !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic check_decode(input alu_op_e e_alu, input logic e_imm, input logic e_sa,
                                input logic e_we, input logic e_re, input logic e_wm,
                                input reg_addr_t e_dest, input string name);
        wait_valid();
        expect_word(alu_op, e_alu, {name, " alu_op"});
        expect_word(src2_is_imm, e_imm, {name, " src2_is_imm"});
        expect_word(src1_is_sa, e_sa, {name, " src1_is_sa"});
        expect_word(gr_we, e_we, {name, " gr_we"});
        expect_word(mem_re, e_re, {name, " mem_re"});
        expect_word(mem_we, e_wm, {name, " mem_we"});
        if (e_we) begin
            expect_word(dest, e_dest, {name, " dest"});
        end
    endtask

    task automatic check_branch(input word_t inst, input logic e_taken, input word_t e_target,
                                input string name);
        send(inst);
        expect_word(br_taken, e_taken, {name, " br_taken"});
        expect_word(br_target, e_target, {name, " br_target"});
        expect_word(ds_pc, pc4 - 4, {name, " ds_pc"});   // pc the branch was fetched at
        expect_word(imm, inst[15:0], {name, " imm"});
    endtask

    task automatic pick_branch_fields();
        v      = next_random();
        cur_pc = {v[31:2], 2'b00};
        pc4    = cur_pc + 4;
        v      = next_random();
        im     = v[15:0];
        idx    = v[31:6];
    endtask

    initial begin
        clk = 1'b0;
        errors = 0;
        cycles = 0;
        rng_state = 32'h72ced026;
        cur_pc = 32'h0000_1000;
        shadow[0] = '0;
        reset <= 1'b1;
        fs_to_ds_valid <= 1'b0;
        fs_inst <= '0;
        fs_pc <= '0;
        es_allowin <= 1'b1;
        es_res_valid <= 1'b1;
        es_dest <= '0;
        es_res <= '0;
        ms_res_valid <= 1'b1;
        ms_dest <= '0;
        ms_res <= '0;
        ws_we <= 1'b0;
        ws_waddr <= '0;
        ws_wdata <= '0;
        repeat (LEN_RESET) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_word(ds_to_es_valid, 1'b0, "ds_to_es_valid after reset");
        expect_word(br_taken, 1'b0, "br_taken after reset");
        expect_word(ds_allowin, 1'b1, "ds_allowin after reset");

        // fill every register through writeback and then read each one back
        for (int r = 1; r < `ID_NREGS; r++) begin
            @(posedge clk);
            v = next_random();
            ws_we    <= 1'b1;
            ws_waddr <= reg_addr_t'(r);
            ws_wdata <= v;
            shadow[r] = v;
        end
        @(posedge clk);
        ws_we <= 1'b0;
        for (int r = 0; r < `ID_NREGS; r++) begin
            send(encode_r(reg_addr_t'(r), reg_addr_t'(r ^ 31), 5'd1, 5'd0, fn_or));
            wait_valid();
            expect_word(rs_value, shadow[r], "register read on rs");
            expect_word(rt_value, shadow[r ^ 31], "register read on rt");
        end

        send(encode_r(5'd2, 5'd3, 5'd4, 5'd0, fn_addu));
        check_decode(alu_add, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 5'd4, "addu");
        send(encode_i(op_addiu, 5'd5, 5'd6, 16'hfff0));
        check_decode(alu_add, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 5'd6, "addiu");
        send(encode_i(op_ori, 5'd7, 5'd8, 16'h00ff));
        check_decode(alu_or, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 5'd8, "ori");
        send(encode_i(op_lui, 5'd0, 5'd9, 16'h1234));
        check_decode(alu_lui, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 5'd9, "lui");
        send(encode_r(5'd0, 5'd10, 5'd11, 5'd3, fn_sll));
        check_decode(alu_sll, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 5'd11, "sll");
        send(encode_i(op_lw, 5'd12, 5'd13, 16'h0010));
        check_decode(alu_add, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 5'd13, "lw");
        send(encode_i(op_sw, 5'd14, 5'd15, 16'h0020));
        check_decode(alu_add, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 5'd0, "sw");

        // r5 on all three ports is peeled off one at a time while execute stalls
        fa = next_random();
        fb = next_random();
        fc = next_random();
        @(posedge clk);
        es_allowin <= 1'b0;
        es_dest    <= 5'd5;
        es_res     <= fa;
        ms_dest    <= 5'd5;
        ms_res     <= fb;
        ws_we      <= 1'b1;
        ws_waddr   <= 5'd5;
        ws_wdata   <= fc;
        shadow[5] = fc;
        send(encode_r(5'd5, 5'd0, 5'd1, 5'd0, fn_addu));
        wait_valid();
        expect_word(rs_value, fa, "rs forwarded from execute");
        @(posedge clk);
        es_dest <= 5'd0;   // es_res stays on the bus and must not reach r0
        @(negedge clk);
        expect_word(rs_value, fb, "rs forwarded from memory");
        expect_word(rt_value, 32'h0, "r0 with dest 0 on execute");
        v = next_random();
        @(posedge clk);
        ms_dest  <= 5'd0;
        ws_wdata <= v;     // file still holds the old value this cycle
        shadow[5] = v;
        @(negedge clk);
        expect_word(rs_value, v, "rs forwarded from writeback");
        @(posedge clk);
        ws_we <= 1'b0;
        @(negedge clk);
        expect_word(rs_value, shadow[5], "rs from the register file");
        @(posedge clk);
        es_allowin <= 1'b1;

        // load-use on r7
        fa = next_random();
        @(posedge clk);
        es_dest      <= 5'd7;
        es_res       <= fa;
        es_res_valid <= 1'b0;
        send(encode_r(5'd7, 5'd0, 5'd2, 5'd0, fn_addu));
        repeat (3) begin
            expect_word(ds_to_es_valid, 1'b0, "ds_to_es_valid during stall");
            expect_word(ds_allowin, 1'b0, "ds_allowin during stall");
            @(negedge clk);
        end
        @(posedge clk);
        es_res_valid <= 1'b1;
        @(negedge clk);
        expect_word(ds_to_es_valid, 1'b1, "ds_to_es_valid when result arrives");
        expect_word(rs_value, fa, "rs after stall");
        @(posedge clk);
        es_res_valid <= 1'b0;
        send(encode_r(5'd7, 5'd0, 5'd3, 5'd2, fn_sll));   // rs field is unused
        expect_word(ds_to_es_valid, 1'b1, "sll with unused rs pending");
        @(posedge clk);
        es_dest      <= 5'd0;
        es_res_valid <= 1'b1;

        pick_branch_fields();
        check_branch(encode_i(op_beq, 5'd4, 5'd4, im), 1'b1,
                     pc4 + {{14{im[15]}}, im, 2'b00}, "beq equal");
        pick_branch_fields();
        check_branch(encode_i(op_beq, 5'd4, 5'd6, im), shadow[4] == shadow[6],
                     pc4 + {{14{im[15]}}, im, 2'b00}, "beq unequal");
        pick_branch_fields();
        check_branch(encode_i(op_bne, 5'd4, 5'd6, im), shadow[4] != shadow[6],
                     pc4 + {{14{im[15]}}, im, 2'b00}, "bne");
        pick_branch_fields();
        check_branch({op_j, idx}, 1'b1, {pc4[31:28], idx, 2'b00}, "j");
        pick_branch_fields();
        check_branch({op_jal, idx}, 1'b1, {pc4[31:28], idx, 2'b00}, "jal");
        expect_word(dest, `ID_LINK_REG, "jal dest");
        expect_word(src1_is_pc, 1'b1, "jal src1_is_pc");
        expect_word(src2_is_8, 1'b1, "jal src2_is_8");
        pick_branch_fields();
        check_branch(encode_r(5'd8, 5'd0, 5'd0, 5'd0, fn_jr), 1'b1, shadow[8], "jr");

        // stage drains and an empty stage never redirects
        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_word(br_taken, 1'b0, "br_taken with empty stage");
        expect_word(ds_to_es_valid, 1'b0, "ds_to_es_valid with empty stage");

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
source/id_pkg.sv
source/id_stage_ctrl.sv
source/id_decoder.sv
source/id_regfile.sv
source/id_bypass_net.sv
source/id_branch_unit.sv
source/id_stage.sv
bench/id_stage_tb.sv

// File: include/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath and register file sizing
`define ID_XLEN      32
`define ID_RAW       5
`define ID_NREGS     32

// jal writes its return address here
`define ID_LINK_REG  31

// instruction field positions
`define ID_OP_MSB    31
`define ID_OP_LSB    26
`define ID_RS_LSB    21   // rs, bits 25:21
`define ID_RT_LSB    16   // rt, bits 20:16
`define ID_RD_LSB    11   // rd, bits 15:11
`define ID_SA_LSB    6    // shamt, bits 10:6

`endif

// File: source/id_branch_unit.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_branch_unit (
    input  logic             ds_valid,
    input  id_pkg::br_kind_e br_kind,
    input  id_pkg::word_t    rs_value,
    input  id_pkg::word_t    rt_value,
    input  logic [15:0]      imm,
    input  logic [25:0]      jidx,
    input  id_pkg::word_t    fs_pc,      // delay slot pc
    output logic             br_taken,
    output id_pkg::word_t    br_target
);

    import id_pkg::*;

    logic  rs_eq_rt;
    logic  cond;
    word_t branch_addr;
    word_t jump_addr;

    assign rs_eq_rt = (rs_value == rt_value);

    // pc-relative off the delay slot
    assign branch_addr = fs_pc + {{(`ID_XLEN-18){imm[15]}}, imm, 2'b00};
    // region jump keeps the top nibble
    assign jump_addr   = {fs_pc[`ID_XLEN-1:`ID_XLEN-4], jidx, 2'b00};

    always_comb begin
        cond      = 1'b0;
        br_target = branch_addr;
        case (br_kind)
            br_beq: cond = rs_eq_rt;
            br_bne: cond = !rs_eq_rt;
            br_j, br_jal: begin
                cond      = 1'b1;
                br_target = jump_addr;
            end
            br_jr: begin
                cond      = 1'b1;
                br_target = rs_value;
            end
            default: ;
        endcase
    end

    assign br_taken = ds_valid && cond;   // empty stage never redirects

endmodule

// File: source/id_bypass_net.sv
`timescale 1ns/1ps

module id_bypass_net (
    input  id_pkg::reg_addr_t rs_addr,
    input  id_pkg::reg_addr_t rt_addr,
    input  logic              uses_rs,
    input  logic              uses_rt,
    input  logic              es_res_valid,
    input  id_pkg::reg_addr_t es_dest,
    input  id_pkg::word_t     es_res,
    input  logic              ms_res_valid,
    input  id_pkg::reg_addr_t ms_dest,
    input  id_pkg::word_t     ms_res,
    input  logic              ws_we,
    input  id_pkg::reg_addr_t ws_waddr,
    input  id_pkg::word_t     ws_wdata,
    input  id_pkg::word_t     rf_rs_data,
    input  id_pkg::word_t     rf_rt_data,
    output id_pkg::word_t     rs_value,
    output id_pkg::word_t     rt_value,
    output logic              src_pending
);

    import id_pkg::*;

    // youngest producer wins over older ones and the file
    function automatic word_t pick_value(input reg_addr_t addr, input word_t rf_data);
        if (addr == '0) begin
            return '0;
        end
        if (addr == es_dest) begin
            return es_res;
        end
        if (addr == ms_dest) begin
            return ms_res;
        end
        if (ws_we && (addr == ws_waddr)) begin
            return ws_wdata;
        end
        return rf_data;
    endfunction

    // a used source waiting on a result that is not out yet
    function automatic logic is_waiting(input reg_addr_t addr, input logic used);
        logic hit_es;
        logic hit_ms;
        hit_es = (addr != '0) && (addr == es_dest);
        hit_ms = (addr != '0) && (addr == ms_dest);
        return used && ((hit_es && !es_res_valid) || (hit_ms && !ms_res_valid));
    endfunction

    always_comb begin
        rs_value    = pick_value(rs_addr, rf_rs_data);
        rt_value    = pick_value(rt_addr, rf_rt_data);
        src_pending = is_waiting(rs_addr, uses_rs) || is_waiting(rt_addr, uses_rt);
    end

endmodule

// File: source/id_decoder.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_decoder (
    input  id_pkg::word_t     ds_inst,
    output id_pkg::alu_op_e   alu_op,
    output logic              src1_is_sa,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output logic              src2_is_8,
    output logic              gr_we,
    output logic              mem_re,
    output logic              mem_we,
    output id_pkg::reg_addr_t dest,
    output logic [15:0]       imm,
    output id_pkg::reg_addr_t rs_addr,
    output id_pkg::reg_addr_t rt_addr,
    output logic              uses_rs,
    output logic              uses_rt,
    output id_pkg::br_kind_e  br_kind,
    output logic [25:0]       jidx
);

    import id_pkg::*;

    opcode_e   op;
    funct_e    fn;
    reg_addr_t rd_addr;

    assign op      = opcode_e'(ds_inst[`ID_OP_MSB:`ID_OP_LSB]);
    assign fn      = funct_e'(ds_inst[5:0]);
    assign rs_addr = ds_inst[`ID_RS_LSB +: `ID_RAW];
    assign rt_addr = ds_inst[`ID_RT_LSB +: `ID_RAW];
    assign rd_addr = ds_inst[`ID_RD_LSB +: `ID_RAW];
    assign imm     = ds_inst[15:0];
    assign jidx    = ds_inst[25:0];

    always_comb begin
        alu_op      = alu_add;
        src1_is_sa  = 1'b0;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        src2_is_8   = 1'b0;
        gr_we       = 1'b0;
        mem_re      = 1'b0;
        mem_we      = 1'b0;
        dest        = '0;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        br_kind     = br_none;

        case (op)
            op_special: begin
                // R-type ALU: rd <- rs op rt unless overridden below
                gr_we   = 1'b1;
                dest    = rd_addr;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                case (fn)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_sllv: alu_op = alu_sll;
                    fn_srlv: alu_op = alu_srl;
                    fn_srav: alu_op = alu_sra;
                    fn_sll, fn_srl, fn_sra: begin
                        // shamt field replaces rs
                        alu_op     = (fn == fn_sll) ? alu_sll :
                                     (fn == fn_srl) ? alu_srl : alu_sra;
                        src1_is_sa = 1'b1;
                        uses_rs    = 1'b0;
                    end
                    fn_jr: begin
                        gr_we   = 1'b0;
                        uses_rt = 1'b0;
                        br_kind = br_jr;
                    end
                    default: begin
                        gr_we   = 1'b0;   // unsupported funct, no effect
                        uses_rs = 1'b0;
                        uses_rt = 1'b0;
                    end
                endcase
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lw: begin
                alu_op      = (op == op_slti)  ? alu_slt  :
                              (op == op_sltiu) ? alu_sltu :
                              (op == op_andi)  ? alu_and  :
                              (op == op_ori)   ? alu_or   :
                              (op == op_xori)  ? alu_xor  : alu_add;
                src2_is_imm = 1'b1;
                gr_we       = 1'b1;
                dest        = rt_addr;
                uses_rs     = 1'b1;
                mem_re      = (op == op_lw);
            end
            op_lui: begin
                alu_op      = alu_lui;
                src2_is_imm = 1'b1;
                gr_we       = 1'b1;
                dest        = rt_addr;
            end
            op_sw: begin
                src2_is_imm = 1'b1;   // address is rs + imm
                mem_we      = 1'b1;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
            end
            op_beq, op_bne: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                br_kind = (op == op_beq) ? br_beq : br_bne;
            end
            op_j:   br_kind = br_j;
            op_jal: begin
                // link value is pc + 8 computed in execute
                src1_is_pc = 1'b1;
                src2_is_8  = 1'b1;
                gr_we      = 1'b1;
                dest       = reg_addr_t'(`ID_LINK_REG);
                br_kind    = br_jal;
            end
            default: ;
        endcase
    end

endmodule

// File: source/id_pkg.sv
`include "id_settings.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0] word_t;
    typedef logic [`ID_RAW-1:0]  reg_addr_t;

    // major opcodes, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // funct codes under special
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_sllv = 6'h04,
        fn_srlv = 6'h06,
        fn_srav = 6'h07,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_j, br_jal, br_jr
    } br_kind_e;

endpackage

// File: source/id_regfile.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    input  logic              we,
    input  id_pkg::reg_addr_t waddr,
    input  id_pkg::word_t     wdata,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2
);

    import id_pkg::*;

    word_t regs [`ID_NREGS];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, r0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic              clk,
    input  logic              reset,
    // fetch
    input  logic              fs_to_ds_valid,
    input  id_pkg::word_t     fs_inst,
    input  id_pkg::word_t     fs_pc,
    output logic              ds_allowin,
    // execute handshake
    input  logic              es_allowin,
    // forwarding sources
    input  logic              es_res_valid,
    input  id_pkg::reg_addr_t es_dest,
    input  id_pkg::word_t     es_res,
    input  logic              ms_res_valid,
    input  id_pkg::reg_addr_t ms_dest,
    input  id_pkg::word_t     ms_res,
    input  logic              ws_we,
    input  id_pkg::reg_addr_t ws_waddr,
    input  id_pkg::word_t     ws_wdata,
    // to execute
    output logic              ds_to_es_valid,
    output id_pkg::alu_op_e   alu_op,
    output logic              src1_is_sa,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output logic              src2_is_8,
    output logic              gr_we,
    output logic              mem_re,
    output logic              mem_we,
    output id_pkg::reg_addr_t dest,
    output logic [15:0]       imm,
    output id_pkg::word_t     rs_value,
    output id_pkg::word_t     rt_value,
    output id_pkg::word_t     ds_pc,
    // redirect to fetch
    output logic              br_taken,
    output id_pkg::word_t     br_target
);

    import id_pkg::*;

    logic        ds_valid;
    word_t       ds_inst;
    logic        src_pending;
    reg_addr_t   rs_addr;
    reg_addr_t   rt_addr;
    logic        uses_rs;
    logic        uses_rt;
    br_kind_e    br_kind;
    logic [25:0] jidx;
    word_t       rf_rs_data;
    word_t       rf_rt_data;

    id_stage_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_inst        (fs_inst),
        .fs_pc          (fs_pc),
        .es_allowin     (es_allowin),
        .src_pending    (src_pending),
        .ds_valid       (ds_valid),
        .ds_inst        (ds_inst),
        .ds_pc          (ds_pc),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid)
    );

    id_decoder u_dec (
        .ds_inst     (ds_inst),
        .alu_op      (alu_op),
        .src1_is_sa  (src1_is_sa),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .src2_is_8   (src2_is_8),
        .gr_we       (gr_we),
        .mem_re      (mem_re),
        .mem_we      (mem_we),
        .dest        (dest),
        .imm         (imm),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .uses_rs     (uses_rs),
        .uses_rt     (uses_rt),
        .br_kind     (br_kind),
        .jidx        (jidx)
    );

    // writeback port drives the file directly
    id_regfile u_rf (
        .clk    (clk),
        .raddr1 (rs_addr),
        .raddr2 (rt_addr),
        .we     (ws_we),
        .waddr  (ws_waddr),
        .wdata  (ws_wdata),
        .rdata1 (rf_rs_data),
        .rdata2 (rf_rt_data)
    );

    id_bypass_net u_byp (
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .uses_rs      (uses_rs),
        .uses_rt      (uses_rt),
        .es_res_valid (es_res_valid),
        .es_dest      (es_dest),
        .es_res       (es_res),
        .ms_res_valid (ms_res_valid),
        .ms_dest      (ms_dest),
        .ms_res       (ms_res),
        .ws_we        (ws_we),
        .ws_waddr     (ws_waddr),
        .ws_wdata     (ws_wdata),
        .rf_rs_data   (rf_rs_data),
        .rf_rt_data   (rf_rt_data),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .src_pending  (src_pending)
    );

    id_branch_unit u_br (
        .ds_valid  (ds_valid),
        .br_kind   (br_kind),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .imm       (imm),
        .jidx      (jidx),
        .fs_pc     (fs_pc),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

// File: source/id_stage_ctrl.sv
`timescale 1ns/1ps

module id_stage_ctrl (
    input  logic          clk,
    input  logic          reset,
    // from fetch
    input  logic          fs_to_ds_valid,
    input  id_pkg::word_t fs_inst,
    input  id_pkg::word_t fs_pc,
    // from execute
    input  logic          es_allowin,
    // from the bypass network
    input  logic          src_pending,
    output logic          ds_valid,
    output id_pkg::word_t ds_inst,
    output id_pkg::word_t ds_pc,
    output logic          ds_allowin,
    output logic          ds_to_es_valid
);

    import id_pkg::*;

    logic  ready_go;
    logic  fs_fire;
    word_t inst_q;
    word_t pc_q;

    // ready to leave once no source waits on an unready result
    assign ready_go = !src_pending;

    // empty, or the held instruction moves on this cycle
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    assign fs_fire = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;   // drains to empty when fetch has nothing
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (fs_fire) begin
            inst_q <= fs_inst;
            pc_q   <= fs_pc;
        end
    end

    assign ds_inst = inst_q;
    assign ds_pc   = pc_q;

endmodule
